/* card_sink_pkg.sv */
package card_sink_pkg;

  // ----------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------

  // Regions and id width
  localparam int N_REGIONS      = 4;
  localparam int N_REGIONS_BITS = 2;

  // Stream word
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = 8;

  // Beat count minus one
  localparam int LEN_BITS = 8;

  // Buffering
  localparam int REGION_DEPTH = 16;
  localparam int CMD_DEPTH    = 8;

  // Derived pointer and occupancy widths
  localparam int REGION_PTR_BITS = $clog2(REGION_DEPTH);
  localparam int REGION_CNT_BITS = $clog2(REGION_DEPTH + 1);
  localparam int CMD_PTR_BITS    = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_BITS    = $clog2(CMD_DEPTH + 1);

  // Header bits above id and len
  localparam int HDR_RSVD_BITS = DATA_BITS - N_REGIONS_BITS - LEN_BITS;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------

  // One stream beat, 73 bits
  typedef struct packed {
    logic [DATA_BITS-1:0] tdata;
    logic [KEEP_BITS-1:0] tkeep;
    logic                 tlast;
  } axis_beat_t;

  // One packet command, region and beats minus one
  typedef struct packed {
    logic [N_REGIONS_BITS-1:0] id;
    logic [LEN_BITS-1:0]       len;
  } mux_cmd_t;

  // Header view, len in the low bits
  typedef struct packed {
    logic [HDR_RSVD_BITS-1:0]  rsvd;
    logic [N_REGIONS_BITS-1:0] id;
    logic [LEN_BITS-1:0]       len;
  } ingress_hdr_t;

  // Ingress tdata, header beat or payload beat
  typedef union packed {
    ingress_hdr_t         hdr;
    logic [DATA_BITS-1:0] data;
  } ingress_word_u;

endpackage

/* region_fifo.sv */
module region_fifo import card_sink_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       wr_en,
  input  axis_beat_t wr_beat,
  output logic       full,
  input  logic       rd_en,
  output logic       head_valid,
  output axis_beat_t head_beat
);

  // Beat storage
  axis_beat_t mem [REGION_DEPTH];

  // Circular pointers and fill level
  logic [REGION_PTR_BITS-1:0] wr_ptr;
  logic [REGION_PTR_BITS-1:0] rd_ptr;
  logic [REGION_CNT_BITS-1:0] count;

  // ----------------------------------------------------------
  // Flags and head
  // ----------------------------------------------------------

  assign full       = (count == REGION_CNT_BITS'(REGION_DEPTH));
  assign head_valid = (count != '0);

  // Head read straight from storage
  assign head_beat = mem[rd_ptr];

  // ----------------------------------------------------------
  // Write and read
  // ----------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous write and read keeps the level
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Full slot only reused when the head leaves on the same edge
  assert property (@(posedge aclk) disable iff (!aresetn) (wr_en && full) |-> rd_en);

  // Mux drains only a present head
  assert property (@(posedge aclk) disable iff (!aresetn) rd_en |-> head_valid);

endmodule

/* ingress_parser.sv */
module ingress_parser import card_sink_pkg::*; (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  axis_beat_t           in_beat,
  output logic [N_REGIONS-1:0] wr_en,
  output axis_beat_t           wr_beat,
  input  logic [N_REGIONS-1:0] fifo_full,
  output logic                 cmd_ready,
  input  logic                 cmd_valid,
  output mux_cmd_t             cmd
);

  typedef enum logic [0:0] {ST_HDR, ST_PAYLOAD} state_t;

  // Packet FSM
  state_t                    state_c, state_n;
  logic [N_REGIONS_BITS-1:0] id_c, id_n;
  logic [LEN_BITS-1:0]       len_c, len_n;
  logic [LEN_BITS-1:0]       cnt_c, cnt_n;

  // Ingress decode
  ingress_word_u in_word;
  logic          in_fire;
  logic          last_beat;

  // Command queue
  mux_cmd_t                cmdq_mem [CMD_DEPTH];
  logic [CMD_PTR_BITS-1:0] cmdq_wr_ptr;
  logic [CMD_PTR_BITS-1:0] cmdq_rd_ptr;
  logic [CMD_CNT_BITS-1:0] cmdq_count;
  logic                    cmdq_full;
  logic                    cmdq_push;
  logic                    cmdq_pop;

  // ----------------------------------------------------------
  // Ingress side
  // ----------------------------------------------------------

  assign in_word   = in_beat.tdata;
  assign in_fire   = in_valid & in_ready;
  assign last_beat = (cnt_c == len_c);

  // Headers wait on queue space, payload on the target region
  assign in_ready = (state_c == ST_HDR) ? ~cmdq_full : ~fifo_full[id_c];

  // Payload beat with tlast rebuilt from the count
  assign wr_beat.tdata = in_word.data;
  assign wr_beat.tkeep = in_beat.tkeep;
  assign wr_beat.tlast = last_beat;

  always_comb begin
    state_n   = state_c;
    id_n      = id_c;
    len_n     = len_c;
    cnt_n     = cnt_c;
    cmdq_push = 1'b0;
    wr_en     = '0;

    case (state_c)
      ST_HDR: begin
        if (in_fire) begin
          // Header beat, queue the command and latch it
          cmdq_push = 1'b1;
          id_n      = in_word.hdr.id;
          len_n     = in_word.hdr.len;
          cnt_n     = '0;
          state_n   = ST_PAYLOAD;
        end
      end

      ST_PAYLOAD: begin
        if (in_fire) begin
          wr_en[id_c] = 1'b1;
          cnt_n       = cnt_c + 1'b1;
          // Back to header after beat len
          if (last_beat) begin
            state_n = ST_HDR;
          end
        end
      end

      default: state_n = ST_HDR;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_c <= ST_HDR;
      id_c    <= '0;
      len_c   <= '0;
      cnt_c   <= '0;
    end else begin
      state_c <= state_n;
      id_c    <= id_n;
      len_c   <= len_n;
      cnt_c   <= cnt_n;
    end
  end

  // ----------------------------------------------------------
  // Command queue
  // ----------------------------------------------------------

  assign cmdq_full = (cmdq_count == CMD_CNT_BITS'(CMD_DEPTH));
  assign cmdq_pop  = cmd_valid;
  assign cmd_ready = (cmdq_count != '0);
  assign cmd       = cmdq_mem[cmdq_rd_ptr];

  // Storage
  always_ff @(posedge aclk) begin
    if (cmdq_push) begin
      cmdq_mem[cmdq_wr_ptr] <= '{id: in_word.hdr.id, len: in_word.hdr.len};
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      cmdq_wr_ptr <= '0;
      cmdq_rd_ptr <= '0;
      cmdq_count  <= '0;
    end else begin
      if (cmdq_push) begin
        cmdq_wr_ptr <= cmdq_wr_ptr + 1'b1;
      end
      if (cmdq_pop) begin
        cmdq_rd_ptr <= cmdq_rd_ptr + 1'b1;
      end
      // Occupancy holds on push and pop together
      case ({cmdq_push, cmdq_pop})
        2'b10:   cmdq_count <= cmdq_count + 1'b1;
        2'b01:   cmdq_count <= cmdq_count - 1'b1;
        default: cmdq_count <= cmdq_count;
      endcase
    end
  end

  // Header never queued into a full queue
  assert property (@(posedge aclk) disable iff (!aresetn) cmdq_push |-> !cmdq_full);

  // Mux pops only a queued command
  assert property (@(posedge aclk) disable iff (!aresetn) cmd_valid |-> cmd_ready);

  // At most one region written per beat
  assert property (@(posedge aclk) disable iff (!aresetn) $onehot0(wr_en));

endmodule

/* axis_mux_user_sink.sv */
module axis_mux_user_sink import card_sink_pkg::*; (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         cmd_ready,
  output logic                         cmd_valid,
  input  mux_cmd_t                     cmd,
  input  logic       [N_REGIONS-1:0]   head_valid,
  input  axis_beat_t [N_REGIONS-1:0]   head_beat,
  output logic       [N_REGIONS-1:0]   rd_en,
  output logic                         out_valid,
  input  logic                         out_ready,
  output axis_beat_t                   out_beat
);

  typedef enum logic [0:0] {ST_IDLE, ST_MUX} state_t;

  // FSM
  state_t state_c, state_n;

  // Active packet
  logic [N_REGIONS_BITS-1:0] id_c, id_n;
  logic [LEN_BITS-1:0]       cnt_c, cnt_n;
  logic [LEN_BITS-1:0]       n_beats_c, n_beats_n;

  // Handshake and end of packet
  logic out_fire;
  logic tr_done;

  // ----------------------------------------------------------
  // Mux
  // ----------------------------------------------------------

  always_comb begin
    rd_en = '0;
    if (state_c == ST_MUX) begin
      // Selected region drives the output
      out_valid   = head_valid[id_c];
      out_beat    = head_beat[id_c];
      rd_en[id_c] = head_valid[id_c] & out_ready;
    end else begin
      out_valid = 1'b0;
      out_beat  = '0;
    end
  end

  assign out_fire = out_valid & out_ready;

  // Beat len of the packet leaves
  assign tr_done = (cnt_c == n_beats_c) & out_fire;

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------

  always_comb begin
    state_n = state_c;
    case (state_c)
      ST_IDLE: state_n = cmd_ready ? ST_MUX : ST_IDLE;
      // Stay in mux when the next command is already queued
      ST_MUX:  state_n = (tr_done && !cmd_ready) ? ST_IDLE : ST_MUX;
      default: state_n = ST_IDLE;
    endcase
  end

  // ----------------------------------------------------------
  // Datapath and command pop
  // ----------------------------------------------------------

  always_comb begin
    cnt_n     = cnt_c;
    id_n      = id_c;
    n_beats_n = n_beats_c;
    cmd_valid = 1'b0;

    case (state_c)
      ST_IDLE: begin
        cnt_n = '0;
        if (cmd_ready) begin
          cmd_valid = 1'b1;
          id_n      = cmd.id;
          n_beats_n = cmd.len;
        end
      end

      ST_MUX: begin
        if (tr_done) begin
          cnt_n = '0;
          // Pop next command with no gap
          if (cmd_ready) begin
            cmd_valid = 1'b1;
            id_n      = cmd.id;
            n_beats_n = cmd.len;
          end
        end else if (out_fire) begin
          cnt_n = cnt_c + 1'b1;
        end
      end

      default: cnt_n = '0;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_c   <= ST_IDLE;
      id_c      <= '0;
      cnt_c     <= '0;
      n_beats_c <= '0;
    end else begin
      state_c   <= state_n;
      id_c      <= id_n;
      cnt_c     <= cnt_n;
      n_beats_c <= n_beats_n;
    end
  end

  // Nothing leaves without an active command
  assert property (@(posedge aclk) disable iff (!aresetn) (state_c == ST_IDLE) |-> !out_valid);

  // Only the selected region is drained
  assert property (@(posedge aclk) disable iff (!aresetn)
    (rd_en & ~(N_REGIONS'(1) << id_c)) == '0);

endmodule

/* card_sink_top.sv */
module card_sink_top import card_sink_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       in_valid,
  output logic       in_ready,
  input  axis_beat_t in_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output axis_beat_t out_beat
);

  // Parser to region FIFOs
  logic       [N_REGIONS-1:0] wr_en;
  axis_beat_t                 wr_beat;
  logic       [N_REGIONS-1:0] fifo_full;

  // Region FIFOs to mux
  logic       [N_REGIONS-1:0] head_valid;
  axis_beat_t [N_REGIONS-1:0] head_beat;
  logic       [N_REGIONS-1:0] rd_en;

  // Command strobes
  logic     cmd_ready;
  logic     cmd_valid;
  mux_cmd_t cmd;

  // ----------------------------------------------------------
  // Header strip and steering
  // ----------------------------------------------------------

  ingress_parser u_parser (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .wr_en     (wr_en),
    .wr_beat   (wr_beat),
    .fifo_full (fifo_full),
    .cmd_ready (cmd_ready),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

  // One buffer per region
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
    region_fifo u_region (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .wr_en      (wr_en[i]),
      .wr_beat    (wr_beat),
      .full       (fifo_full[i]),
      .rd_en      (rd_en[i]),
      .head_valid (head_valid[i]),
      .head_beat  (head_beat[i])
    );
  end

  // ----------------------------------------------------------
  // Output mux
  // ----------------------------------------------------------

  axis_mux_user_sink u_mux (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_ready  (cmd_ready),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .head_valid (head_valid),
    .head_beat  (head_beat),
    .rd_en      (rd_en),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

/* card_sink_checker.sv */
module card_sink_checker import card_sink_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       in_valid,
  input  logic       in_ready,
  input  axis_beat_t in_beat,
  input  logic       out_valid,
  input  logic       out_ready,
  input  axis_beat_t out_beat,
  input  logic       end_check,
  output int         err_count,
  output int         pending_beats
);

  // Ingress tracking
  ingress_word_u hdr_q;
  logic          in_payload;
  int            seq;
  int            idx;

  // Beats still owed by the DUT, oldest first
  axis_beat_t exp_q[$];
  axis_beat_t exp;

  // Payload word is sequence number over beat index
  // Keep is full except on the last beat, which carries the sent keep
  function automatic axis_beat_t expected_beat(input logic [LEN_BITS-1:0] len,
                                               input int seq_num,
                                               input int beat_idx,
                                               input logic [KEEP_BITS-1:0] last_keep);
    axis_beat_t b;
    b.tdata = {seq_num[31:0], beat_idx[31:0]};
    b.tlast = (beat_idx == int'(len));
    b.tkeep = b.tlast ? last_keep : '1;
    return b;
  endfunction

  // ----------------------------------------------------------
  // Monitor and compare
  // ----------------------------------------------------------

  always @(posedge aclk) begin
    if (!aresetn) begin
      in_payload = 1'b0;
      seq        = 0;
      idx        = 0;
      err_count  = 0;
      exp_q.delete();
    end else begin
      // Header latches the packet, payload beats queue expectations
      if (in_valid && in_ready) begin
        if (!in_payload) begin
          hdr_q      = in_beat.tdata;
          idx        = 0;
          in_payload = 1'b1;
        end else begin
          exp_q.push_back(expected_beat(hdr_q.hdr.len, seq, idx, in_beat.tkeep));
          if (idx == int'(hdr_q.hdr.len)) begin
            in_payload = 1'b0;
            seq        = seq + 1;
          end
          idx = idx + 1;
        end
      end

      // Output handshake
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output beat %h arrived with no payload beat left to match", out_beat);
          err_count = err_count + 1;
        end else begin
          exp = exp_q.pop_front();
          if (out_beat !== exp) begin
            $display("FAILED out_beat got %h expected %h", out_beat, exp);
            err_count = err_count + 1;
          end
        end
      end

      // End of test, everything sent must have come out
      if (end_check && exp_q.size() != 0) begin
        $display("%0d payload beats are missing from the output", exp_q.size());
        err_count = err_count + 1;
        exp_q.delete();
      end
    end
    pending_beats = exp_q.size();
  end

endmodule

/* tb_card_sink.sv */
module tb_card_sink import card_sink_pkg::*; ();

  localparam int N_RAND      = 40;
  localparam int DRAIN_LIMIT = 1000;

  // DUT ports
  logic       aclk;
  logic       aresetn;
  logic       in_valid;
  logic       in_ready;
  axis_beat_t in_beat;
  logic       out_valid;
  logic       out_ready;
  axis_beat_t out_beat;

  // Checker hookup
  logic end_check;
  int   chk_errs;
  int   pending;

  // Random packet lists, test 4 then test 5
  logic [N_REGIONS_BITS-1:0] rand_id [2*N_RAND];
  logic [LEN_BITS-1:0]       rand_len [2*N_RAND];

  // Bookkeeping
  int   pkt_seq;
  int   tb_errs;
  int   errs_before;
  int   test_num;
  int   pass_cnt;
  int   fail_cnt;
  int   cycles;
  int   cycle_limit;
  int   total;
  int   n;
  logic ready_random;

  card_sink_top u_card_sink_top (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  card_sink_checker u_checker (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_beat       (in_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_beat      (out_beat),
    .end_check     (end_check),
    .err_count     (chk_errs),
    .pending_beats (pending)
  );

  // ----------------------------------------------------------
  // Clock, sink ready and hang guard
  // ----------------------------------------------------------

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // Steady or 40 percent ready
  always @(negedge aclk) begin
    if (ready_random) begin
      out_ready = (($urandom % 100) < 40);
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Simulation hang, no finish after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------

  // Optional idle cycles, then hold the beat until taken
  task automatic drive_beat(input axis_beat_t b, input int max_gap);
    int gap;
    gap = (max_gap == 0) ? 0 : int'($urandom % (max_gap + 1));
    repeat (gap) begin
      @(negedge aclk);
      in_valid = 1'b0;
    end
    @(negedge aclk);
    in_valid = 1'b1;
    in_beat  = b;
    while (!in_ready) @(negedge aclk);
  endtask

  task automatic send_packet(input logic [N_REGIONS_BITS-1:0] id,
                             input logic [LEN_BITS-1:0] len, input int max_gap);
    ingress_word_u w;
    axis_beat_t    b;
    int            i;
    // Header through the union's header view
    w        = '0;
    w.hdr.id = id;
    w.hdr.len = len;
    b.tdata  = w.data;
    b.tkeep  = '1;
    b.tlast  = 1'b0;
    drive_beat(b, max_gap);
    for (i = 0; i <= int'(len); i++) begin
      b.tdata = {pkt_seq[31:0], i[31:0]};
      b.tlast = (i == int'(len));
      // Partial contiguous keep on the last beat
      b.tkeep = b.tlast ? (8'hff >> ($urandom % 8)) : 8'hff;
      drive_beat(b, max_gap);
    end
    pkt_seq = pkt_seq + 1;
  endtask

  task automatic go_idle();
    @(negedge aclk);
    in_valid = 1'b0;
  endtask

  // Drain, ask the checker for leftovers, report the test
  task automatic finish_test(input string name);
    int waited;
    int errs;
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(negedge aclk);
      waited = waited + 1;
    end
    repeat (10) @(negedge aclk);
    end_check = 1'b1;
    @(negedge aclk);
    end_check = 1'b0;
    errs        = tb_errs + chk_errs - errs_before;
    errs_before = tb_errs + chk_errs;
    test_num    = test_num + 1;
    if (errs == 0) begin
      pass_cnt = pass_cnt + 1;
      $display("Test %0d (%s): passed", test_num, name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("Test %0d (%s): failed with %0d errors", test_num, name, errs);
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    void'($urandom(32'h30e9));
    in_valid     = 1'b0;
    in_beat      = '0;
    out_ready    = 1'b1;
    end_check    = 1'b0;
    ready_random = 1'b0;
    aresetn      = 1'b0;
    pkt_seq = 0;
    tb_errs = 0;
    errs_before = 0;
    test_num = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cycles = 0;
    cycle_limit = 0;

    // Random lists up front so the limit covers every beat
    total = 33 + 24;
    for (n = 0; n < 2 * N_RAND; n++) begin
      rand_id[n]  = N_REGIONS_BITS'($urandom % N_REGIONS);
      rand_len[n] = LEN_BITS'($urandom % 24);
      total       = total + int'(rand_len[n]) + 2;
    end
    cycle_limit = 8 * total + 2000;

    repeat (16) @(negedge aclk);
    aresetn = 1'b1;

    // Idle after reset
    repeat (20) begin
      @(negedge aclk);
      if (out_valid !== 1'b0) begin
        $display("FAILED out_valid got %h expected %h", out_valid, 1'b0);
        tb_errs = tb_errs + 1;
      end
      if (in_ready !== 1'b1) begin
        $display("FAILED in_ready got %h expected %h", in_ready, 1'b1);
        tb_errs = tb_errs + 1;
      end
    end
    finish_test("reset state");

    send_packet(2'd0, 8'd0, 0);
    send_packet(2'd1, 8'd3, 0);
    send_packet(2'd2, 8'd7, 0);
    send_packet(2'd3, 8'd15, 0);
    go_idle();
    finish_test("one packet per region");

    // Region rotation, single beats
    for (n = 0; n < 12; n++) begin
      send_packet(N_REGIONS_BITS'(n % N_REGIONS), 8'd0, 0);
    end
    go_idle();
    finish_test("back-to-back single beats");

    for (n = 0; n < N_RAND; n++) begin
      send_packet(rand_id[n], rand_len[n], 0);
    end
    go_idle();
    finish_test("random regions and lengths");

    // Sink stalls and ingress gaps
    ready_random = 1'b1;
    for (n = N_RAND; n < 2 * N_RAND; n++) begin
      send_packet(rand_id[n], rand_len[n], 3);
    end
    go_idle();
    finish_test("random ready and gaps");
    ready_random = 1'b0;

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* card_sink.f */
card_sink_pkg.sv
region_fifo.sv
ingress_parser.sv
axis_mux_user_sink.sv
card_sink_top.sv
card_sink_checker.sv
tb_card_sink.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the card sink testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module tb_card_sink -f card_sink.f \
  -Mdir "$OBJ" -o tb_card_sink
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_card_sink" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
